//--- all.f
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/mem_unit.sv
logic/core_top.sv
dv/wb_memory.sv
dv/core_tb.sv

//--- dv/core_tb.sv
// rv64 core testbench
`timescale 1ns/1ps

module core_tb;

    localparam int unsigned     seed      = 32'h87e5_ff49;
    localparam int              timeout   = 2000;
    localparam logic [11:0]     data_base = 12'h400;
    localparam core_pkg::addr_t start_pc  = 64'h0;
    // jal x0, 0
    localparam core_pkg::inst_t halt_inst = 32'h0000_006f;

    logic                clk;
    logic                rst;
    core_pkg::ibus_req_t ibus_req;
    core_pkg::ibus_rsp_t ibus_rsp;
    core_pkg::dbus_req_t dbus_req;
    core_pkg::dbus_rsp_t dbus_rsp;

    core_pkg::inst_t  prog [$];
    core_pkg::addr_t  store_adr [$];
    core_pkg::xword_t store_dat [$];
    int               checks;
    int               mismatches;
    int               timeouts;

    core_top #(
        .rst_pc (start_pc)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp)
    );

    wb_memory mem_i (
        .clk      (clk),
        .rst      (rst),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp)
    );

    always #10 clk = ~clk;

    // data bus writes, recorded at ack
    always @(posedge clk) begin
        if (!rst && dbus_req.cyc && dbus_req.stb && dbus_req.we && dbus_rsp.ack) begin
            store_adr.push_back(dbus_req.adr);
            store_dat.push_back(dbus_req.dat);
        end
    end

    function automatic core_pkg::xword_t sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    function automatic core_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
    endfunction

    function automatic core_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], core_pkg::op_store};
    endfunction

    function automatic core_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::op_branch};
    endfunction

    function automatic core_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::op_jal};
    endfunction

    function automatic logic [11:0] slot_off(input int slot);
        return data_base + 12'(slot * 8);
    endfunction

    function automatic core_pkg::addr_t slot_adr(input int slot);
        return 64'(slot_off(slot));
    endfunction

    function automatic core_pkg::inst_t store_inst(input logic [4:0] rs2, input int slot);
        return enc_s(slot_off(slot), rs2, 5'd0);
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // lui then addi, value follows the sign-extension rules
    task automatic load_const(input logic [4:0] rd, output core_pkg::xword_t value);
        logic [19:0] upper;
        logic [11:0] lower;
        upper = 20'($urandom());
        lower = 12'($urandom());
        prog.push_back({upper, rd, core_pkg::op_lui});
        prog.push_back(enc_i(lower, rd, 3'b000, rd, core_pkg::op_imm));
        value = {{32{upper[19]}}, upper, 12'h000} + sext12(lower);
    endtask

    task automatic restart(input string name);
        int n;
        @(posedge clk);
        rst <= 1'b1;
        for (n = 0; n < 10; n++) begin
            @(posedge clk);
            if (n == 1) begin
                mem_i.fill();
                foreach (prog[k]) begin
                    mem_i.put_inst(64'(k) * 4, prog[k]);
                end
            end
            if (n > 0) begin
                check($sformatf("%s cyc in reset", name), 64'd0,
                      {62'd0, ibus_req.cyc, dbus_req.cyc});
            end
        end
        store_adr.delete();
        store_dat.delete();
        rst <= 1'b0;
    endtask

    task automatic wait_store(input string name, input core_pkg::addr_t adr,
                              input core_pkg::xword_t value);
        int n;
        for (n = 0; n < timeout && store_adr.size() == 0; n++) begin
            @(posedge clk);
        end
        if (store_adr.size() == 0) begin
            timeouts++;
            $display("%s: no data bus write to %h within %0d cycles", name, adr, timeout);
        end else begin
            check($sformatf("%s address", name), adr, store_adr.pop_front());
            check($sformatf("%s data", name), value, store_dat.pop_front());
        end
    endtask

    task automatic test_reset();
        int n;
        prog.delete();
        prog.push_back(halt_inst);
        restart("reset");
        for (n = 0; n < timeout && !ibus_req.cyc; n++) begin
            @(posedge clk);
        end
        if (!ibus_req.cyc) begin
            timeouts++;
            $display("reset: no instruction fetch within %0d cycles", timeout);
        end else begin
            check("reset first fetch", start_pc, ibus_req.adr);
        end
    endtask

    task automatic test_alu();
        core_pkg::xword_t a;
        core_pkg::xword_t b;
        core_pkg::xword_t want [9];
        logic [11:0]      imm [4];
        int               k;
        prog.delete();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (k = 0; k < 4; k++) begin
            imm[k] = 12'($urandom());
        end
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        prog.push_back(enc_i(imm[0], 5'd1, 3'b000, 5'd8, core_pkg::op_imm));
        prog.push_back(enc_i(imm[1], 5'd1, 3'b111, 5'd9, core_pkg::op_imm));
        prog.push_back(enc_i(imm[2], 5'd1, 3'b110, 5'd10, core_pkg::op_imm));
        prog.push_back(enc_i(imm[3], 5'd1, 3'b100, 5'd11, core_pkg::op_imm));
        want = '{a + b, a - b, a & b, a | b, a ^ b, a + sext12(imm[0]),
                 a & sext12(imm[1]), a | sext12(imm[2]), a ^ sext12(imm[3])};
        for (k = 0; k < 9; k++) begin
            prog.push_back(store_inst(5'(k + 3), k));
        end
        prog.push_back(halt_inst);
        restart("alu");
        for (k = 0; k < 9; k++) begin
            wait_store($sformatf("alu op %0d", k), slot_adr(k), want[k]);
        end
    endtask

    task automatic test_chain();
        core_pkg::xword_t value;
        logic [11:0]      imm;
        int               k;
        prog.delete();
        load_const(5'd1, value);
        // each addi reads the result of the one before
        for (k = 0; k < 10; k++) begin
            imm = 12'($urandom());
            prog.push_back(enc_i(imm, 5'd1, 3'b000, 5'd1, core_pkg::op_imm));
            value = value + sext12(imm);
        end
        prog.push_back(store_inst(5'd1, 0));
        prog.push_back(halt_inst);
        restart("chain");
        wait_store("chain", slot_adr(0), value);
    endtask

    task automatic test_mem();
        core_pkg::xword_t value;
        prog.delete();
        load_const(5'd1, value);
        prog.push_back(store_inst(5'd1, 0));
        prog.push_back(enc_i(slot_off(0), 5'd0, 3'b011, 5'd2, core_pkg::op_load));
        prog.push_back(enc_i(12'd1, 5'd2, 3'b000, 5'd2, core_pkg::op_imm));
        prog.push_back(store_inst(5'd2, 1));
        prog.push_back(halt_inst);
        restart("mem");
        wait_store("mem first store", slot_adr(0), value);
        wait_store("mem second store", slot_adr(1), value + 1);
    endtask

    task automatic test_branch();
        core_pkg::xword_t value;
        core_pkg::addr_t  jal_pc;
        prog.delete();
        load_const(5'd1, value);
        prog.push_back(enc_i(12'd0, 5'd1, 3'b000, 5'd2, core_pkg::op_imm));
        // marker register, its store must never reach the bus
        prog.push_back(enc_i(12'h5a5, 5'd0, 3'b000, 5'd3, core_pkg::op_imm));
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
        prog.push_back(store_inst(5'd3, 3));
        prog.push_back(store_inst(5'd1, 0));
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
        prog.push_back(store_inst(5'd1, 1));
        jal_pc = 64'(prog.size()) * 4;
        prog.push_back(enc_j(21'd8, 5'd5));
        prog.push_back(store_inst(5'd3, 3));
        prog.push_back(store_inst(5'd5, 2));
        prog.push_back(halt_inst);
        restart("branch");
        wait_store("beq taken", slot_adr(0), value);
        wait_store("bne not taken", slot_adr(1), value);
        wait_store("jal link", slot_adr(2), jal_pc + 4);
    endtask

    initial begin
        int unsigned seed_val;
        seed_val   = $urandom(seed);
        clk        = 1'b0;
        rst        = 1'b1;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        test_reset();
        test_alu();
        test_chain();
        test_mem();
        test_branch();
        $display("%0d checks, %0d mismatches, %0d timeouts", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/wb_memory.sv
// wishbone test memory
`timescale 1ns/1ps

module wb_memory #(
    parameter int depth = 1024
) (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::ibus_req_t ibus_req,
    output core_pkg::ibus_rsp_t ibus_rsp,
    input  core_pkg::dbus_req_t dbus_req,
    output core_pkg::dbus_rsp_t dbus_rsp
);

    localparam int aw = $clog2(depth);

    core_pkg::xword_t mem [depth];
    core_pkg::xword_t i_word;
    logic [aw-1:0]    d_idx;
    int               i_count;
    int               i_delay;
    int               d_count;
    int               d_delay;

    assign i_word = mem[ibus_req.adr[aw+2:3]];
    assign d_idx  = dbus_req.adr[aw+2:3];

    initial begin
        ibus_rsp = '0;
        dbus_rsp = '0;
    end

    function automatic core_pkg::xword_t byte_merge(input core_pkg::xword_t old,
                                                    input core_pkg::xword_t data,
                                                    input logic [7:0] sel);
        core_pkg::xword_t merged;
        merged = old;
        for (int b = 0; b < 8; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // every doubleword gets a value hashed from its index
    task automatic fill();
        int k;
        for (k = 0; k < depth; k++) begin
            mem[k] = 64'(k) * 64'h9e37_79b9_7f4a_7c15;
        end
    endtask

    task automatic put_inst(input core_pkg::addr_t adr, input core_pkg::inst_t inst);
        if (adr[2]) begin
            mem[adr[aw+2:3]][63:32] = inst;
        end else begin
            mem[adr[aw+2:3]][31:0] = inst;
        end
    endtask

    // instruction port, read only
    always @(posedge clk) begin
        if (rst) begin
            ibus_rsp.ack <= 1'b0;
            i_count      <= 0;
            i_delay      <= $urandom_range(5);
        end else if (ibus_rsp.ack) begin
            ibus_rsp.ack <= 1'b0;
        end else if (ibus_req.cyc && ibus_req.stb) begin
            if (i_count >= i_delay) begin
                ibus_rsp.ack <= 1'b1;
                ibus_rsp.dat <= ibus_req.adr[2] ? i_word[63:32] : i_word[31:0];
                i_count      <= 0;
                i_delay      <= $urandom_range(5);
            end else begin
                i_count <= i_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            dbus_rsp.ack <= 1'b0;
            d_count      <= 0;
            d_delay      <= $urandom_range(5);
        end else if (dbus_rsp.ack) begin
            dbus_rsp.ack <= 1'b0;
        end else if (dbus_req.cyc && dbus_req.stb) begin
            if (d_count >= d_delay) begin
                dbus_rsp.ack <= 1'b1;
                dbus_rsp.dat <= mem[d_idx];
                if (dbus_req.we) begin
                    mem[d_idx] <= byte_merge(mem[d_idx], dbus_req.dat, dbus_req.sel);
                end
                d_count <= 0;
                d_delay <= $urandom_range(5);
            end else begin
                d_count <= d_count + 1;
            end
        end
    end

endmodule

//--- logic/core_top.sv
// rv64 pipeline core top
`timescale 1ns/1ps

module core_top #(
    parameter core_pkg::addr_t rst_pc = '0
) (
    input  logic                clk,
    input  logic                rst,
    output core_pkg::ibus_req_t ibus_req,
    input  core_pkg::ibus_rsp_t ibus_rsp,
    output core_pkg::dbus_req_t dbus_req,
    input  core_pkg::dbus_rsp_t dbus_rsp
);

    core_pkg::if_id_t   if_data;
    logic               if_valid;
    logic               id_ready;
    core_pkg::id_ex_t   id_data;
    logic               id_valid;
    logic               ex_ready;
    core_pkg::ex_mem_t  ex_data;
    logic               ex_valid;
    logic               mem_ready;
    core_pkg::wb_t      wb;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::xword_t   rs1_data;
    core_pkg::xword_t   rs2_data;
    logic               redirect;
    core_pkg::addr_t    redirect_pc;

    fetch_unit #(
        .rst_pc (rst_pc)
    ) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .ibus_req    (ibus_req),
        .ibus_rsp    (ibus_rsp),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .if_valid    (if_valid),
        .if_out      (if_data),
        .id_ready    (id_ready)
    );

    decode_unit u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_valid (if_valid),
        .if_in    (if_data),
        .id_ready (id_ready),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb),
        .redirect (redirect),
        .id_valid (id_valid),
        .id_out   (id_data),
        .ex_ready (ex_ready)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst         (rst),
        .id_valid    (id_valid),
        .id_in       (id_data),
        .ex_ready    (ex_ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_valid    (ex_valid),
        .ex_out      (ex_data),
        .mem_ready   (mem_ready)
    );

    mem_unit u_mem (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_in     (ex_data),
        .mem_ready (mem_ready),
        .dbus_req  (dbus_req),
        .dbus_rsp  (dbus_rsp),
        .wb        (wb)
    );

endmodule

//--- logic/mem_unit.sv
// load/store and writeback
`timescale 1ns/1ps

module mem_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_valid,
    input  core_pkg::ex_mem_t   ex_in,
    output logic                mem_ready,
    output core_pkg::dbus_req_t dbus_req,
    input  core_pkg::dbus_rsp_t dbus_rsp,
    output core_pkg::wb_t       wb
);

    core_pkg::mem_state_e state;
    logic                 mem_op;

    assign mem_op = ex_in.is_load || ex_in.is_store;

    // loads and stores leave only when the bus acks
    assign mem_ready = (state == core_pkg::mem_idle) ? !(ex_valid && mem_op)
                                                     : dbus_rsp.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= core_pkg::mem_idle;
            dbus_req.cyc <= 1'b0;
            dbus_req.stb <= 1'b0;
            dbus_req.we  <= 1'b0;
            wb.wen       <= 1'b0;
        end else begin
            wb.wen <= 1'b0;
            case (state)
                core_pkg::mem_idle: begin
                    if (ex_valid && mem_op) begin
                        state        <= core_pkg::mem_access;
                        dbus_req.cyc <= 1'b1;
                        dbus_req.stb <= 1'b1;
                        dbus_req.we  <= ex_in.is_store;
                        dbus_req.adr <= ex_in.result;
                        dbus_req.sel <= 8'hff;
                        dbus_req.dat <= ex_in.store_data;
                    end else if (ex_valid) begin
                        wb.wen  <= ex_in.rd_wen;
                        wb.rd   <= ex_in.rd;
                        wb.data <= ex_in.result;
                    end
                end
                core_pkg::mem_access: begin
                    if (dbus_rsp.ack) begin
                        state        <= core_pkg::mem_idle;
                        dbus_req.cyc <= 1'b0;
                        dbus_req.stb <= 1'b0;
                        dbus_req.we  <= 1'b0;
                        // stores carry no rd_wen
                        wb.wen       <= ex_in.rd_wen;
                        wb.rd        <= ex_in.rd;
                        wb.data      <= dbus_rsp.dat;
                    end
                end
                default: state <= core_pkg::mem_idle;
            endcase
        end
    end

    a_idle_no_cyc: assert property (@(posedge clk) disable iff (rst)
        state == core_pkg::mem_idle |-> !dbus_req.cyc);

    a_we_store: assert property (@(posedge clk) disable iff (rst)
        dbus_req.we |-> ex_valid && ex_in.is_store);

endmodule

//--- logic/execute_unit.sv
// alu and branch resolution
`timescale 1ns/1ps

module execute_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              id_valid,
    input  core_pkg::id_ex_t  id_in,
    output logic              ex_ready,
    output logic              redirect,
    output core_pkg::addr_t   redirect_pc,
    output logic              ex_valid,
    output core_pkg::ex_mem_t ex_out,
    input  logic              mem_ready
);

    core_pkg::xword_t alu_res;
    logic             taken;
    logic             fire;

    assign ex_ready = !ex_valid || mem_ready;
    assign fire     = id_valid && ex_ready;

    always_comb begin
        case (id_in.alu_op)
            core_pkg::alu_sub:    alu_res = id_in.a - id_in.b;
            core_pkg::alu_and:    alu_res = id_in.a & id_in.b;
            core_pkg::alu_or:     alu_res = id_in.a | id_in.b;
            core_pkg::alu_xor:    alu_res = id_in.a ^ id_in.b;
            core_pkg::alu_pass_b: alu_res = id_in.b;
            default:              alu_res = id_in.a + id_in.b;
        endcase
    end

    // beq when equal, bne when not
    assign taken = id_in.is_jal
                || (id_in.is_branch && ((id_in.a == id_in.b) != id_in.branch_ne));

    assign redirect    = fire && taken;
    assign redirect_pc = id_in.pc + id_in.offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (fire) begin
            ex_valid <= 1'b1;
        end else if (mem_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            // jal links to the next instruction
            ex_out.result     <= id_in.is_jal ? id_in.pc + 64'd4 : alu_res;
            ex_out.store_data <= id_in.store_data;
            ex_out.rd         <= id_in.rd;
            ex_out.rd_wen     <= id_in.rd_wen;
            ex_out.is_load    <= id_in.is_load;
            ex_out.is_store   <= id_in.is_store;
        end
    end

endmodule

//--- logic/reg_file.sv
// integer register file
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::xword_t   rs1_data,
    output core_pkg::xword_t   rs2_data,
    input  core_pkg::wb_t      wb
);

    core_pkg::xword_t regs [32];

    function automatic core_pkg::xword_t read_port(core_pkg::reg_idx_t idx,
                                                   core_pkg::xword_t stored,
                                                   core_pkg::wb_t w);
        if (idx == '0) begin
            return '0;
        end
        // same-cycle write goes straight through
        if (w.wen && w.rd == idx) begin
            return w.data;
        end
        return stored;
    endfunction

    assign rs1_data = read_port(rs1, regs[rs1], wb);
    assign rs2_data = read_port(rs2, regs[rs2], wb);

    always_ff @(posedge clk) begin
        if (!rst && wb.wen && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

//--- logic/decode_unit.sv
// instruction decode and issue
`timescale 1ns/1ps

module decode_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               if_valid,
    input  core_pkg::if_id_t   if_in,
    output logic               id_ready,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    input  core_pkg::xword_t   rs1_data,
    input  core_pkg::xword_t   rs2_data,
    input  core_pkg::wb_t      wb,
    input  logic               redirect,
    output logic               id_valid,
    output core_pkg::id_ex_t   id_out,
    input  logic               ex_ready
);

    core_pkg::inst_t  inst;
    logic [6:0]       opcode;
    core_pkg::xword_t imm_i;
    core_pkg::xword_t imm_s;
    core_pkg::xword_t imm_b;
    core_pkg::xword_t imm_j;
    core_pkg::xword_t imm_u;
    core_pkg::id_ex_t dec;
    logic             uses_rs1;
    logic             uses_rs2;
    logic [31:0]      busy;
    logic [31:0]      busy_now;
    logic [31:0]      busy_set;
    logic             stall;
    logic             issue;

    assign inst   = if_in.inst;
    assign opcode = inst[6:0];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

    always_comb begin
        dec            = '0;
        dec.pc         = if_in.pc;
        dec.alu_op     = core_pkg::alu_add;
        dec.a          = rs1_data;
        dec.b          = rs2_data;
        dec.store_data = rs2_data;
        dec.rd         = inst[11:7];
        uses_rs1       = 1'b0;
        uses_rs2       = 1'b0;
        case (opcode)
            core_pkg::op_reg, core_pkg::op_imm: begin
                uses_rs1   = 1'b1;
                uses_rs2   = (opcode == core_pkg::op_reg);
                dec.rd_wen = 1'b1;
                if (opcode == core_pkg::op_imm) begin
                    dec.b = imm_i;
                end
                case (inst[14:12])
                    3'b000: begin
                        if (uses_rs2 && inst[30]) begin
                            dec.alu_op = core_pkg::alu_sub;
                        end
                    end
                    3'b100: dec.alu_op = core_pkg::alu_xor;
                    3'b110: dec.alu_op = core_pkg::alu_or;
                    3'b111: dec.alu_op = core_pkg::alu_and;
                    // shifts and compares are not supported
                    default: dec.rd_wen = 1'b0;
                endcase
            end
            core_pkg::op_lui: begin
                dec.b      = imm_u;
                dec.alu_op = core_pkg::alu_pass_b;
                dec.rd_wen = 1'b1;
            end
            core_pkg::op_load: begin
                uses_rs1    = 1'b1;
                dec.b       = imm_i;
                dec.is_load = 1'b1;
                dec.rd_wen  = 1'b1;
            end
            core_pkg::op_store: begin
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                dec.b        = imm_s;
                dec.is_store = 1'b1;
            end
            core_pkg::op_branch: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.is_branch = 1'b1;
                dec.branch_ne = inst[12];
                dec.offset    = imm_b;
            end
            core_pkg::op_jal: begin
                dec.is_jal = 1'b1;
                dec.rd_wen = 1'b1;
                dec.offset = imm_j;
            end
            default: ;
        endcase
        if (dec.rd == '0) begin
            dec.rd_wen = 1'b0;
        end
    end

    // the register file bypasses this cycle's write, so its bit is free now
    assign busy_now = wb.wen ? (busy & ~(32'd1 << wb.rd)) : busy;
    assign stall    = (uses_rs1 && busy_now[rs1]) || (uses_rs2 && busy_now[rs2])
                    || (dec.rd_wen && busy_now[dec.rd]);
    assign id_ready = !stall && (!id_valid || ex_ready);
    assign issue    = if_valid && id_ready && !redirect;
    assign busy_set = (issue && dec.rd_wen) ? (32'd1 << dec.rd) : 32'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= '0;
            id_valid <= 1'b0;
        end else begin
            busy <= busy_now | busy_set;
            if (redirect) begin
                id_valid <= 1'b0;
            end else if (issue) begin
                id_valid <= 1'b1;
            end else if (ex_ready) begin
                id_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            id_out <= dec;
        end
    end

    // every writeback retires a destination that the scoreboard tracks
    a_wb_tracked: assert property (@(posedge clk) disable iff (rst)
        wb.wen |-> busy[wb.rd]);

endmodule

//--- logic/fetch_unit.sv
// instruction fetch
`timescale 1ns/1ps

module fetch_unit #(
    parameter core_pkg::addr_t rst_pc = '0
) (
    input  logic                clk,
    input  logic                rst,
    output core_pkg::ibus_req_t ibus_req,
    input  core_pkg::ibus_rsp_t ibus_rsp,
    input  logic                redirect,
    input  core_pkg::addr_t     redirect_pc,
    output logic                if_valid,
    output core_pkg::if_id_t    if_out,
    input  logic                id_ready
);

    core_pkg::addr_t pc;
    core_pkg::addr_t fetch_adr;
    logic            discard;
    logic            bus_done;
    logic            start;
    logic            take;

    assign fetch_adr = redirect ? redirect_pc : pc;
    assign bus_done  = ibus_req.cyc && ibus_rsp.ack;
    // only one access at a time, and only when the held slot frees up
    assign start     = !ibus_req.cyc && (!if_valid || id_ready || redirect);
    assign take      = bus_done && !discard && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= rst_pc;
            discard      <= 1'b0;
            if_valid     <= 1'b0;
            ibus_req.cyc <= 1'b0;
            ibus_req.stb <= 1'b0;
        end else begin
            if ((if_valid && id_ready) || redirect) begin
                if_valid <= 1'b0;
            end
            if (take) begin
                if_valid <= 1'b1;
                pc       <= ibus_req.adr + 64'd4;
            end
            if (redirect) begin
                pc <= redirect_pc;
            end
            if (start) begin
                ibus_req.cyc <= 1'b1;
                ibus_req.stb <= 1'b1;
                ibus_req.adr <= fetch_adr;
            end else if (bus_done) begin
                ibus_req.cyc <= 1'b0;
                ibus_req.stb <= 1'b0;
            end
            // a response still in flight at redirect belongs to the old path
            if (bus_done) begin
                discard <= 1'b0;
            end else if (redirect && ibus_req.cyc) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if_out.pc   <= ibus_req.adr;
            if_out.inst <= ibus_rsp.dat;
        end
    end

    a_adr_stable: assert property (@(posedge clk) disable iff (rst)
        ibus_req.stb && !ibus_rsp.ack |=> ibus_req.stb && $stable(ibus_req.adr));

endmodule

//--- logic/core_pkg.sv
// rv64 core shared types
package core_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xword_t;
    typedef logic [63:0]     addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    // base opcodes of the kept instructions
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_e;

    typedef enum logic {
        mem_idle,
        mem_access
    } mem_state_e;

    // wishbone classic, instruction side
    typedef struct packed {
        logic  cyc;
        logic  stb;
        addr_t adr;
    } ibus_req_t;

    typedef struct packed {
        logic  ack;
        inst_t dat;
    } ibus_rsp_t;

    // wishbone classic, data side
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        addr_t      adr;
        logic [7:0] sel;
        xword_t     dat;
    } dbus_req_t;

    typedef struct packed {
        logic   ack;
        xword_t dat;
    } dbus_rsp_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        addr_t    pc;
        alu_op_e  alu_op;
        xword_t   a;
        xword_t   b;
        xword_t   store_data;
        reg_idx_t rd;
        logic     rd_wen;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;
        logic     is_jal;
        xword_t   offset;
    } id_ex_t;

    typedef struct packed {
        xword_t   result;
        xword_t   store_data;
        reg_idx_t rd;
        logic     rd_wen;
        logic     is_load;
        logic     is_store;
    } ex_mem_t;

    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xword_t   data;
    } wb_t;

endpackage
